// ==== Bender.yml ====
package:
  name: lsu_secded

sources:
  - files:
      - hdl/ahb_pkg.sv
      - hdl/lsu_pkg.sv
      - hdl/secded_encode.sv
      - hdl/secded_decode.sv
      - hdl/lsu.sv
      - hdl/ahb_ecc_ram.sv
      - hdl/lsu_subsys_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/lsu_checker.sv
      - dv/lsu_tb.sv

// ==== dv/lsu_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response checker for the load/store subsystem
// Shadow byte memory and expected-result queue
// Reference load extraction, error counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lsu_checker (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  logic                                        req_valid_i,
    input  lsu_pkg::lsu_op_e                            req_op_i,
    input  logic [ahb_pkg::ADDR_W-1:0]                  req_addr_i,
    input  logic [ahb_pkg::DATA_W-1:0]                  req_wdata_i,
    input  logic                                        req_busy_i,
    input  logic                                        rsp_valid_i,
    input  logic [ahb_pkg::DATA_W-1:0]                  rsp_rdata_i,
    input  logic [lsu_pkg::EINFO_W-1:0]                 rsp_einfo_i,
    input  logic                                        rsp_error_i,
    input  logic [ahb_pkg::DATA_W+ahb_pkg::CHECK_W-1:0] inject_i,   // Held per request
    output int                                          checks_o,
    output int                                          errors_o,
    output int                                          pending_o    // Open requests
);

    localparam int RSP_LIMIT = 200;   // Cycles without any response

    typedef struct packed {
        lsu_pkg::lsu_op_e op;
        logic [31:0]      addr;
        logic [31:0]      data;       // Expected load value
        logic [2:0]       einfo;
        logic             bus_err;
        logic             cmp_data;   // Loads without a double upset
    } exp_t;

    exp_t       exp_q[$];                          // In request order
    logic [7:0] shadow [lsu_pkg::MEM_WORDS*4];
    logic       rmw_watch;                          // Sub-word store taken last edge
    int         quiet;

    // Expected load value, sign or zero extended
    function automatic logic [31:0] load_ref(input lsu_pkg::lsu_op_e op, input logic [1:0] ofs,
                                             input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*ofs +: 8];
        h = ofs[1] ? word[31:16] : word[15:0];
        case (op)
            lsu_pkg::LB:  load_ref = $signed(b);
            lsu_pkg::LBU: load_ref = b;
            lsu_pkg::LH:  load_ref = $signed(h);
            lsu_pkg::LHU: load_ref = h;
            default:      load_ref = word;
        endcase
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        shadow_word = {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};   // Little endian
    endfunction

    // One flip is corrected, two are flagged
    function automatic logic [2:0] upset_info(input logic [38:0] flips);
        upset_info = '0;
        if (flips != '0)
            upset_info[lsu_pkg::EINFO_ERR] = 1'b1;
        if ($countones(flips) == 1)
            upset_info[lsu_pkg::EINFO_CE] = 1'b1;
        if ($countones(flips) == 2)
            upset_info[lsu_pkg::EINFO_UCE] = 1'b1;
    endfunction

    task automatic store_bytes(input lsu_pkg::lsu_op_e op, input logic [31:0] a,
                               input logic [31:0] d);
        case (op)
            lsu_pkg::SB: shadow[a] = d[7:0];
            lsu_pkg::SH: begin
                shadow[{a[31:1], 1'b0}] = d[7:0];
                shadow[{a[31:1], 1'b1}] = d[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++)
                    shadow[{a[31:2], 2'b00} + i] = d[8*i +: 8];
            end
        endcase
    endtask

    task automatic compare(input exp_t e);
        checks_o++;
        if (rsp_error_i !== e.bus_err || rsp_einfo_i !== e.einfo) begin
            $display("Error at %0t: op %h addr %h error/einfo %b/%b, expected %b/%b",
                     $time, e.op, e.addr, rsp_error_i, rsp_einfo_i, e.bus_err, e.einfo);
            errors_o++;
        end
        if (e.cmp_data && rsp_rdata_i !== e.data) begin
            $display("Error at %0t: op %h addr %h data %h, expected %h",
                     $time, e.op, e.addr, rsp_rdata_i, e.data);
            errors_o++;
        end
    endtask

    always @(posedge clk_i) begin : watch
        exp_t e;
        logic bad;
        if (reset_i) begin
            for (int i = 0; i < lsu_pkg::MEM_WORDS*4; i++)
                shadow[i] = 8'h00;                  // Memory clears to zero
            exp_q.delete();
            rmw_watch = 1'b0;
            quiet     = 0;
            checks_o  = 0;
            errors_o  = 0;
        end else begin
            if (rmw_watch && !req_busy_i) begin
                $display("Error at %0t: req_busy_o low during a sub-word store", $time);
                errors_o++;
            end
            rmw_watch = 1'b0;
            if (rsp_valid_i) begin
                quiet = 0;
                if (exp_q.size() == 0) begin
                    $display("A response arrived with no request outstanding");
                    errors_o++;
                end else begin
                    compare(exp_q.pop_front());
                end
            end else if (exp_q.size() != 0) begin
                quiet++;
                if (quiet == RSP_LIMIT) begin
                    $display("No response for %0d cycles with %0d requests open",
                             RSP_LIMIT, exp_q.size());
                    errors_o++;
                end
            end
            // Response popped first, same-edge request queued behind it
            if (req_valid_i && !req_busy_i) begin
                bad        = req_addr_i >= lsu_pkg::MEM_WORDS * 4;
                e.op       = req_op_i;
                e.addr     = req_addr_i;
                e.bus_err  = bad;
                e.einfo    = (bad || req_op_i == lsu_pkg::SW) ? '0 : upset_info(inject_i);
                e.cmp_data = !bad && !req_op_i[3] && $countones(inject_i) < 2;
                e.data     = bad ? '0 : load_ref(req_op_i, req_addr_i[1:0],
                                                 shadow_word(req_addr_i));
                if (!bad && req_op_i[3]) begin
                    store_bytes(req_op_i, req_addr_i, req_wdata_i);
                    rmw_watch = (req_op_i != lsu_pkg::SW);
                end
                exp_q.push_back(e);
            end
        end
        pending_o = exp_q.size();
    end

endmodule

// ==== dv/lsu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for the SECDED load/store subsystem
// Random traffic, sub-word stores, upsets, bus errors
// Random wait states on the memory side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lsu_tb;

    localparam int WAIT_LIMIT = 200;                          // Cycles per wait loop
    localparam int INJ_W      = ahb_pkg::DATA_W + ahb_pkg::CHECK_W;

    logic                         clk, reset;
    logic                         req_valid, req_busy, rsp_valid, rsp_error;
    lsu_pkg::lsu_op_e             req_op;
    logic [ahb_pkg::ADDR_W-1:0]   req_addr;
    logic [ahb_pkg::DATA_W-1:0]   req_wdata, rsp_rdata;
    logic [lsu_pkg::EINFO_W-1:0]  rsp_einfo;
    logic                         stall, stall_en, hung;
    logic [INJ_W-1:0]             inject;
    int                           checks, errors, pending, timeouts;
    lsu_pkg::lsu_op_e             ops [8];                    // Loads first, then stores

    tb_clock_gen clk_gen_i (.clk_o(clk), .reset_o(reset));

    lsu_subsys_top dut_i (
        .s_clk_i     (clk),
        .reset_i     (reset),
        .req_valid_i (req_valid),
        .req_op_i    (req_op),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .req_busy_o  (req_busy),
        .rsp_valid_o (rsp_valid),
        .rsp_rdata_o (rsp_rdata),
        .rsp_einfo_o (rsp_einfo),
        .rsp_error_o (rsp_error),
        .stall_i     (stall),
        .inject_i    (inject)
    );

    lsu_checker checker_i (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_valid_i (req_valid),
        .req_op_i    (req_op),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .req_busy_i  (req_busy),
        .rsp_valid_i (rsp_valid),
        .rsp_rdata_i (rsp_rdata),
        .rsp_einfo_i (rsp_einfo),
        .rsp_error_i (rsp_error),
        .inject_i    (inject),
        .checks_o    (checks),
        .errors_o    (errors),
        .pending_o   (pending)
    );

    always @(posedge clk)
        stall <= stall_en && ($urandom % 3 == 0);    // Wait state one cycle in three

    // Stuck wait, later steps fall through to the summary
    task automatic give_up(input string what);
        $display("Timeout: %s within %0d cycles", what, WAIT_LIMIT);
        timeouts++;
        hung = 1'b1;
    endtask

    // Holds the request until an edge with busy low
    task automatic send_req(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
        int   n;
        logic taken;
        if (!hung) begin
            req_valid <= 1'b1;
            req_op    <= op;
            req_addr  <= addr;
            req_wdata <= wdata;
            taken = 1'b0;
            n     = 0;
            while (!taken && n < WAIT_LIMIT) begin
                @(posedge clk);
                taken = !req_busy;                   // Value before this edge
                n++;
            end
            req_valid <= 1'b0;
            if (!taken)
                give_up("request not accepted");
        end
    endtask

    task automatic wait_rsp();
        int n;
        n = 0;
        if (!hung) begin
            do begin
                @(posedge clk);
                n++;
            end while (!rsp_valid && n < WAIT_LIMIT);
            if (!rsp_valid)
                give_up("no response to a single request");
        end
    endtask

    // Until every accepted request has answered
    task automatic drain();
        int   n;
        logic open;
        n = 0;
        if (!hung) begin
            do begin
                @(negedge clk);
                open = (pending != 0);
                n++;
            end while (open && n < WAIT_LIMIT);
            @(posedge clk);
            if (open)
                give_up("responses still outstanding");
        end
    endtask

    // Aligned address for the size, words counted from base
    function automatic logic [31:0] pick_addr(input lsu_pkg::lsu_op_e op, input int words,
                                             input logic [31:0] base);
        logic [31:0] a;
        a = base + ($urandom % words) * 4;
        case (op[1:0])
            2'b00:   a = a + $urandom % 4;
            2'b01:   a = a + 2 * ($urandom % 2);
            default: a = a;
        endcase
        pick_addr = a;
    endfunction

    task automatic run_random(input int count);
        lsu_pkg::lsu_op_e op;
        for (int i = 0; i < count && !hung; i++) begin
            op = ops[$urandom % 8];
            send_req(op, pick_addr(op, 16, 0), $urandom);   // 16 words, lots of reuse
            if ($urandom % 4 == 0)
                @(posedge clk);                               // Idle gap
        end
    endtask

    // Word loads after sub-word stores show the untouched bytes
    task automatic keep_neighbours(input logic [31:0] addr);
        send_req(lsu_pkg::SW, addr, $urandom);
        send_req(lsu_pkg::SB, addr + $urandom % 4, $urandom);
        send_req(lsu_pkg::LW, addr, 0);
        send_req(lsu_pkg::SH, addr + 2 * ($urandom % 2), $urandom);
        send_req(lsu_pkg::LW, addr, 0);
    endtask

    // Flip pattern held for the whole request, nothing else in flight
    task automatic upset_req(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                             input logic [INJ_W-1:0] flips);
        drain();
        inject <= flips;
        send_req(op, addr, $urandom);
        wait_rsp();
        inject <= '0;
    endtask

    task automatic finish_run();
        @(negedge clk);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    initial begin
        lsu_pkg::lsu_op_e op;
        logic [31:0]      a;
        int unsigned      b1, b2;
        void'($urandom(32'h72e76057));
        ops = '{lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW, lsu_pkg::LBU,
                lsu_pkg::LHU, lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
        req_valid = 1'b0;
        req_op    = lsu_pkg::LW;
        req_addr  = '0;
        req_wdata = '0;
        stall     = 1'b0;
        inject    = '0;
        stall_en  = 1'b0;
        hung      = 1'b0;
        timeouts  = 0;
        for (int n = 0; reset !== 1'b0 && n < WAIT_LIMIT; n++)
            @(posedge clk);
        if (reset !== 1'b0)
            give_up("reset release");
        run_random(300);
        for (int i = 0; i < 8 && !hung; i++)
            keep_neighbours(32'h100 + 4 * i);
        for (int i = 0; i < 16 && !hung; i++) begin
            op = ops[$urandom % 5];                   // Single flips on loads
            upset_req(op, pick_addr(op, 16, 0), INJ_W'(1) << ($urandom % INJ_W));
        end
        for (int i = 0; i < 8 && !hung; i++) begin
            op = ops[5 + $urandom % 2];               // Single flip under an RMW
            a  = pick_addr(op, 16, 0);
            upset_req(op, a, INJ_W'(1) << ($urandom % INJ_W));
            send_req(lsu_pkg::LW, {a[31:2], 2'b00}, 0);
        end
        for (int i = 0; i < 12 && !hung; i++) begin
            b1 = $urandom % INJ_W;
            b2 = (b1 + 1 + $urandom % (INJ_W - 1)) % INJ_W;    // Distinct second bit
            op = ops[$urandom % 5];
            upset_req(op, pick_addr(op, 16, 0), (INJ_W'(1) << b1) | (INJ_W'(1) << b2));
        end
        drain();
        for (int i = 0; i < 12 && !hung; i++) begin
            op = ops[$urandom % 8];                   // Past the end of memory
            send_req(op, pick_addr(op, 64, lsu_pkg::MEM_WORDS * 4), $urandom);
            op = ops[$urandom % 8];
            send_req(op, pick_addr(op, 16, 0), $urandom);
        end
        send_req(lsu_pkg::LW, 32'hffff_fffc, 0);
        stall_en <= 1'b1;
        run_random(300);
        drain();
        stall_en <= 1'b0;
        finish_run();
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock, 8 ns period
// Synchronous reset held for 16 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;    // Half period
    end

    initial begin
        reset_o = 1'b1;
        repeat (16) @(posedge clk_o);
        reset_o <= 1'b0;              // Released on a rising edge
    end

endmodule

// ==== hdl/ahb_ecc_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite slave memory, data and checksum per word
// Wait states, two-cycle error response
// Read-path upset injection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ahb_ecc_ram (
    input  logic                                        s_clk_i,
    input  logic                                        reset_i,
    input  logic [ahb_pkg::ADDR_W-1:0]                  haddr_i,
    input  ahb_pkg::htrans_e                            htrans_i,
    input  ahb_pkg::hsize_e                             hsize_i,
    input  logic                                        hwrite_i,
    input  logic [ahb_pkg::DATA_W-1:0]                  hwdata_i,
    input  logic [ahb_pkg::CHECK_W-1:0]                 hwdcheck_i,
    output logic [ahb_pkg::DATA_W-1:0]                  hrdata_o,
    output logic [ahb_pkg::CHECK_W-1:0]                 hrdcheck_o,
    output logic                                        hready_o,
    output logic                                        hresp_o,
    input  logic                                        stall_i,   // Extra wait states
    input  logic [ahb_pkg::DATA_W+ahb_pkg::CHECK_W-1:0] inject_i   // Read-side flips
);

    localparam int WORD_W = ahb_pkg::DATA_W + ahb_pkg::CHECK_W;

    logic [WORD_W-1:0]          mem_q [lsu_pkg::MEM_WORDS];   // {check, data}
    logic [WORD_W-1:0]          rd_word;
    logic                       ap_fire, ap_bad;
    logic                       dp_valid_q, dp_write_q, dp_err_q, err_tail_q;
    logic [lsu_pkg::MEM_AW-1:0] dp_idx_q;

    assign ap_fire = (htrans_i == ahb_pkg::NONSEQ) && hready_o;

    // Out of range, sub-word or unaligned transfers are refused
    // Partial writes would leave a stale checksum
    assign ap_bad = (haddr_i >= ahb_pkg::ADDR_W'(lsu_pkg::MEM_WORDS * 4))
                 || (hsize_i != ahb_pkg::WORD)
                 || (haddr_i[1:0] != 2'b00);

    // Data phase response
    always_comb begin
        hready_o = 1'b1;
        hresp_o  = 1'b0;
        if (dp_valid_q) begin
            if (dp_err_q) begin
                hresp_o  = 1'b1;
                hready_o = err_tail_q;    // Low first, high second cycle
            end else begin
                hready_o = !stall_i;
            end
        end
    end

    // Address phase capture
    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            dp_valid_q <= 1'b0;
            err_tail_q <= 1'b0;
        end else begin
            if (hready_o)
                dp_valid_q <= ap_fire;
            err_tail_q <= dp_valid_q && dp_err_q && !err_tail_q;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (ap_fire) begin
            dp_write_q <= hwrite_i;
            dp_err_q   <= ap_bad;
            dp_idx_q   <= haddr_i[lsu_pkg::MEM_AW+1:2];
        end
    end

    // Storage, cleared to the all-zero codeword
    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            for (int w = 0; w < lsu_pkg::MEM_WORDS; w++)
                mem_q[w] <= '0;
        end else if (dp_valid_q && dp_write_q && !dp_err_q && hready_o) begin
            mem_q[dp_idx_q] <= {hwdcheck_i, hwdata_i};
        end
    end

    // Upsets modelled on the way out of the array
    assign rd_word    = mem_q[dp_idx_q] ^ inject_i;
    assign hrdata_o   = rd_word[ahb_pkg::DATA_W-1:0];
    assign hrdcheck_o = rd_word[WORD_W-1:ahb_pkg::DATA_W];

endmodule

// ==== hdl/ahb_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite transfer type and size encodings
// Address, data and checksum widths of the bus
// SECDED column table shared by encoder and decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ahb_pkg;

    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int CHECK_W = 7;    // 6 Hamming bits plus overall parity

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        NONSEQ = 2'b10
    } htrans_e;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    // Check-bit column of data bit idx
    // Data bits sit on the non power-of-two Hamming positions 3..38
    // Top bit folds the overall parity in, so every column has odd weight
    function automatic logic [CHECK_W-1:0] secded_col(input int unsigned idx);
        logic [5:0]  pos;
        int unsigned seen;
        secded_col = '0;
        seen       = 0;
        for (int unsigned p = 3; p <= 38; p++) begin
            pos = 6'(p);
            if ((pos & (pos - 6'd1)) != 6'd0) begin   // Skip check-bit slots
                if (seen == idx)
                    secded_col = {~^pos, pos};
                seen++;
            end
        end
    endfunction

endpackage

// ==== hdl/lsu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store unit with AHB-Lite master port
// RMW sequencer for sub-word stores
// Load syndrome register, correction, extraction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lsu (
    input  logic                          s_clk_i,
    input  logic                          reset_i,
    // Core request
    input  logic                          req_valid_i,
    input  lsu_pkg::lsu_op_e              req_op_i,
    input  logic [ahb_pkg::ADDR_W-1:0]    req_addr_i,
    input  logic [ahb_pkg::DATA_W-1:0]    req_wdata_i,
    output logic                          req_busy_o,    // No new request this cycle
    // Core response
    output logic                          rsp_valid_o,
    output logic [ahb_pkg::DATA_W-1:0]    rsp_rdata_o,
    output logic [lsu_pkg::EINFO_W-1:0]   rsp_einfo_o,
    output logic                          rsp_error_o,   // Bus error
    // AHB-Lite master
    output logic [ahb_pkg::ADDR_W-1:0]    haddr_o,
    output ahb_pkg::htrans_e              htrans_o,
    output ahb_pkg::hsize_e               hsize_o,
    output logic                          hwrite_o,
    output logic [ahb_pkg::DATA_W-1:0]    hwdata_o,
    output logic [ahb_pkg::CHECK_W-1:0]   hwdcheck_o,
    input  logic [ahb_pkg::DATA_W-1:0]    hrdata_i,
    input  logic [ahb_pkg::CHECK_W-1:0]   hrdcheck_i,
    input  logic                          hready_i,
    input  logic                          hresp_i
);

    lsu_pkg::rmw_state_e               rmw_state_q;
    logic                              req_fire, ap_fire, sub_store;
    logic                              dp_valid_q, dp_write_q, dp_done, dp_rmw_rd;
    lsu_pkg::lsu_op_e                  dp_op_q, rs_op_q;
    logic [ahb_pkg::ADDR_W-1:0]        dp_addr_q;
    logic [1:0]                        rs_addr_q;
    logic                              rs_valid_q, rs_error_q, rs_chk;
    logic [ahb_pkg::DATA_W-1:0]        wdata_q, st_lane, merged, raw_q, fix_data;
    logic [ahb_pkg::DATA_W-1:0]        lane, load_val;
    logic [ahb_pkg::CHECK_W-1:0]       rd_check, syn_q;
    logic [lsu_pkg::EINFO_W-1:0]       dec_einfo;
    logic [3:0]                        byte_mask;

    assign sub_store  = req_op_i[3] && (req_op_i[1:0] != 2'b10);
    assign req_busy_o = (rmw_state_q != lsu_pkg::RMW_IDLE) || !hready_i;
    assign req_fire   = req_valid_i && !req_busy_o;

    // Address phase, held by the core while hready is low
    always_comb begin
        htrans_o = ahb_pkg::IDLE;
        haddr_o  = {req_addr_i[ahb_pkg::ADDR_W-1:2], 2'b00};   // Always word aligned
        hsize_o  = ahb_pkg::WORD;                               // Checksum covers whole word
        hwrite_o = 1'b0;
        if (rmw_state_q == lsu_pkg::RMW_WRITE) begin
            htrans_o = ahb_pkg::NONSEQ;                          // Merged word goes out
            haddr_o  = {dp_addr_q[ahb_pkg::ADDR_W-1:2], 2'b00};
            hwrite_o = 1'b1;
        end else if (rmw_state_q == lsu_pkg::RMW_IDLE && req_valid_i) begin
            htrans_o = ahb_pkg::NONSEQ;
            hwrite_o = req_op_i[3] && !sub_store;              // Sub-word stores read first
        end
    end

    assign ap_fire   = (htrans_o == ahb_pkg::NONSEQ) && hready_i;
    assign dp_done   = dp_valid_q && hready_i;
    assign dp_rmw_rd = !dp_write_q && dp_op_q[3];   // Read half of an RMW

    // RMW sequence
    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            rmw_state_q <= lsu_pkg::RMW_IDLE;
        end else if (hresp_i && !hready_i) begin
            rmw_state_q <= lsu_pkg::RMW_IDLE;     // First error cycle ends the sequence
        end else if (hready_i) begin
            case (rmw_state_q)
                lsu_pkg::RMW_IDLE: begin
                    if (req_fire && sub_store)
                        rmw_state_q <= lsu_pkg::RMW_READ;
                end
                lsu_pkg::RMW_READ:  rmw_state_q <= lsu_pkg::RMW_WRITE;   // Old word is in
                default:            rmw_state_q <= lsu_pkg::RMW_IDLE;    // Write accepted
            endcase
        end
    end

    // Data phase and response control
    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            dp_valid_q <= 1'b0;
            rs_valid_q <= 1'b0;
            rs_error_q <= 1'b0;
        end else begin
            if (hready_i)
                dp_valid_q <= ap_fire;
            rs_valid_q <= dp_done && (hresp_i || !dp_rmw_rd);   // RMW read stays silent
            rs_error_q <= dp_done && hresp_i;
        end
    end

    // Store data into byte lanes
    always_comb begin
        case (req_op_i[1:0])
            2'b00:   st_lane = {4{req_wdata_i[7:0]}};
            2'b01:   st_lane = {2{req_wdata_i[15:0]}};
            default: st_lane = req_wdata_i;
        endcase
    end

    // Lanes owned by the pending sub-word store
    always_comb begin
        if (dp_op_q[1:0] == 2'b00)
            byte_mask = 4'b0001 << dp_addr_q[1:0];
        else
            byte_mask = dp_addr_q[1] ? 4'b1100 : 4'b0011;
    end

    // New bytes over the corrected old word
    always_comb begin
        for (int b = 0; b < 4; b++)
            merged[8*b +: 8] = byte_mask[b] ? wdata_q[8*b +: 8] : fix_data[8*b +: 8];
    end

    always_ff @(posedge s_clk_i) begin
        if (hready_i)
            dp_write_q <= hwrite_o;
        if (req_fire) begin
            dp_op_q   <= req_op_i;
            dp_addr_q <= req_addr_i;
        end
        if (req_fire && req_op_i[3])
            wdata_q <= st_lane;
        else if (rmw_state_q == lsu_pkg::RMW_WRITE && hready_i)
            wdata_q <= merged;                    // Data phase of the RMW write
        if (dp_done && !dp_write_q) begin
            syn_q <= rd_check ^ hrdcheck_i;       // Analysed next cycle
            raw_q <= hrdata_i;
        end
        if (dp_done) begin
            rs_op_q   <= dp_op_q;
            rs_addr_q <= dp_addr_q[1:0];
        end
    end

    secded_encode wr_enc (
        .data_i  (wdata_q),
        .check_o (hwdcheck_o)
    );

    secded_encode rd_enc (
        .data_i  (hrdata_i),
        .check_o (rd_check)
    );

    secded_decode dec (
        .data_i     (raw_q),
        .syndrome_i (syn_q),
        .data_o     (fix_data),
        .einfo_o    (dec_einfo)
    );

    assign hwdata_o = wdata_q;

    // Pick and extend the requested lane
    always_comb begin
        lane = fix_data >> {rs_addr_q, 3'b000};
        case (rs_op_q)
            lsu_pkg::LB:  load_val = {{24{lane[7]}}, lane[7:0]};
            lsu_pkg::LBU: load_val = {24'd0, lane[7:0]};
            lsu_pkg::LH:  load_val = {{16{lane[15]}}, lane[15:0]};
            lsu_pkg::LHU: load_val = {16'd0, lane[15:0]};
            default:      load_val = fix_data;
        endcase
    end

    // Loads and RMW stores carry the syndrome of their read
    assign rs_chk = !rs_error_q && (!rs_op_q[3] || (rs_op_q[1:0] != 2'b10));

    assign rsp_valid_o = rs_valid_q;
    assign rsp_error_o = rs_error_q;
    assign rsp_einfo_o = rs_chk ? dec_einfo : '0;
    assign rsp_rdata_o = (rs_op_q[3] || rs_error_q) ? '0 : load_val;

endmodule

// ==== hdl/lsu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store opcodes and RMW sequence states
// Error-info bit positions, memory depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lsu_pkg;

    // Opcode layout
    // [1:0] size (0 byte, 1 half, 2 word)
    // [2]   unsigned load
    // [3]   store
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    // Sub-word store sequence
    typedef enum logic [1:0] {
        RMW_IDLE  = 2'b00,
        RMW_READ  = 2'b01,   // Aligned read in flight
        RMW_WRITE = 2'b10    // Merged word on the address bus
    } rmw_state_e;

    // Error info bits
    localparam int EINFO_W   = 3;
    localparam int EINFO_ERR = 0;   // Nonzero syndrome
    localparam int EINFO_CE  = 1;   // Single error, corrected
    localparam int EINFO_UCE = 2;   // Uncorrectable

    // Memory depth in words, byte addresses 0..MEM_WORDS*4-1
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

endpackage

// ==== hdl/lsu_subsys_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store unit joined to the SECDED memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lsu_subsys_top (
    input  logic                                        s_clk_i,
    input  logic                                        reset_i,
    input  logic                                        req_valid_i,
    input  lsu_pkg::lsu_op_e                            req_op_i,
    input  logic [ahb_pkg::ADDR_W-1:0]                  req_addr_i,
    input  logic [ahb_pkg::DATA_W-1:0]                  req_wdata_i,
    output logic                                        req_busy_o,
    output logic                                        rsp_valid_o,
    output logic [ahb_pkg::DATA_W-1:0]                  rsp_rdata_o,
    output logic [lsu_pkg::EINFO_W-1:0]                 rsp_einfo_o,
    output logic                                        rsp_error_o,
    input  logic                                        stall_i,
    input  logic [ahb_pkg::DATA_W+ahb_pkg::CHECK_W-1:0] inject_i
);

    // AHB-Lite link
    logic [ahb_pkg::ADDR_W-1:0]  haddr;
    ahb_pkg::htrans_e            htrans;
    ahb_pkg::hsize_e             hsize;
    logic                        hwrite, hready, hresp;
    logic [ahb_pkg::DATA_W-1:0]  hwdata, hrdata;
    logic [ahb_pkg::CHECK_W-1:0] hwdcheck, hrdcheck;

    lsu lsu_i (
        .s_clk_i     (s_clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_busy_o  (req_busy_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_einfo_o (rsp_einfo_o),
        .rsp_error_o (rsp_error_o),
        .haddr_o     (haddr),
        .htrans_o    (htrans),
        .hsize_o     (hsize),
        .hwrite_o    (hwrite),
        .hwdata_o    (hwdata),
        .hwdcheck_o  (hwdcheck),
        .hrdata_i    (hrdata),
        .hrdcheck_i  (hrdcheck),
        .hready_i    (hready),
        .hresp_i     (hresp)
    );

    ahb_ecc_ram ram_i (
        .s_clk_i    (s_clk_i),
        .reset_i    (reset_i),
        .haddr_i    (haddr),
        .htrans_i   (htrans),
        .hsize_i    (hsize),
        .hwrite_i   (hwrite),
        .hwdata_i   (hwdata),
        .hwdcheck_i (hwdcheck),
        .hrdata_o   (hrdata),
        .hrdcheck_o (hrdcheck),
        .hready_o   (hready),
        .hresp_o    (hresp),
        .stall_i    (stall_i),
        .inject_i   (inject_i)
    );

endmodule

// ==== hdl/secded_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SECDED syndrome classification
// Single data-bit correction and error info
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module secded_decode (
    input  logic [ahb_pkg::DATA_W-1:0]   data_i,      // Raw word as read
    input  logic [ahb_pkg::CHECK_W-1:0]  syndrome_i,  // Recomputed ^ stored checksum
    output logic [ahb_pkg::DATA_W-1:0]   data_o,      // Corrected word
    output logic [lsu_pkg::EINFO_W-1:0]  einfo_o      // {uce, ce, err}
);

    logic syn_nz;     // Any error
    logic data_hit;   // Syndrome names a data bit
    logic chk_hit;    // Syndrome names a check bit

    assign syn_nz = |syndrome_i;

    // Flip the one data bit whose column equals the syndrome
    always_comb begin
        data_o   = data_i;
        data_hit = 1'b0;
        for (int i = 0; i < ahb_pkg::DATA_W; i++) begin
            if (syndrome_i == ahb_pkg::secded_col(i)) begin
                data_o[i] = ~data_i[i];
                data_hit  = 1'b1;
            end
        end
    end

    // Check-bit columns are unit vectors, so the syndrome is one-hot
    // Data stays untouched here
    assign chk_hit = syn_nz && ((syndrome_i & (syndrome_i - 7'd1)) == '0);

    always_comb begin
        einfo_o                     = '0;
        einfo_o[lsu_pkg::EINFO_ERR] = syn_nz;
        einfo_o[lsu_pkg::EINFO_CE]  = data_hit | chk_hit;
        // Even-weight or unknown pattern, double flip at least
        einfo_o[lsu_pkg::EINFO_UCE] = syn_nz & ~(data_hit | chk_hit);
    end

endmodule

// ==== hdl/secded_encode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SECDED (39,32) checksum generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module secded_encode (
    input  logic [ahb_pkg::DATA_W-1:0]  data_i,    // Word to protect
    output logic [ahb_pkg::CHECK_W-1:0] check_o    // Hamming bits + overall parity
);

    // Each check bit is the parity of the data bits whose column has it set
    // All-zero word gives all-zero checksum
    always_comb begin
        check_o = '0;
        for (int i = 0; i < ahb_pkg::DATA_W; i++) begin
            if (data_i[i])
                check_o = check_o ^ ahb_pkg::secded_col(i);
        end
    end

endmodule

// ==== list.f ====
hdl/ahb_pkg.sv
hdl/lsu_pkg.sv
hdl/secded_encode.sv
hdl/secded_decode.sv
hdl/lsu.sv
hdl/ahb_ecc_ram.sv
hdl/lsu_subsys_top.sv
dv/tb_clock_gen.sv
dv/lsu_checker.sv
dv/lsu_tb.sv
